// ==== Makefile ====
# Verilator build for the host control path and its testbench
# Any variable can be overridden on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= cl_manycore_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LFLAGS    ?= --lint-only --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/cl_manycore_top.sv ====
// Host control path: AXI4-Lite bridge, request buffer, tile endpoint
// rst_main_n_sync must already be synchronous to clk_main_a0

`timescale 1ns/1ps

module cl_manycore_top
  import mc_link_pkg::*;
(
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  logic                   awvalid_i,
  input  logic [AXIL_ADDR_W-1:0] awaddr_i,
  output logic                   awready_o,
  input  logic                   wvalid_i,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic [AXIL_STRB_W-1:0] wstrb_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output logic [AXIL_RESP_W-1:0] bresp_o,
  input  logic                   bready_i,
  input  logic                   arvalid_i,
  input  logic [AXIL_ADDR_W-1:0] araddr_i,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output logic [AXIL_RESP_W-1:0] rresp_o,
  input  logic                   rready_i
);

  logic         req_valid;
  logic         req_ready;
  link_packet_u req_packet;
  logic         pop_valid;
  logic         pop_ready;
  link_packet_u pop_packet;
  logic         rsp_valid;
  logic         rsp_ready;
  link_packet_u rsp_packet;

  ocl_host_bridge ocl_host_bridge_inst (
    .clk_main_a0_i     (clk_main_a0),
    .rst_main_n_sync_i (rst_main_n_sync),
    .awvalid_i         (awvalid_i),
    .awaddr_i          (awaddr_i),
    .awready_o         (awready_o),
    .wvalid_i          (wvalid_i),
    .wdata_i           (wdata_i),
    .wstrb_i           (wstrb_i),
    .wready_o          (wready_o),
    .bvalid_o          (bvalid_o),
    .bresp_o           (bresp_o),
    .bready_i          (bready_i),
    .arvalid_i         (arvalid_i),
    .araddr_i          (araddr_i),
    .arready_o         (arready_o),
    .rvalid_o          (rvalid_o),
    .rdata_o           (rdata_o),
    .rresp_o           (rresp_o),
    .rready_i          (rready_i),
    .req_valid_o       (req_valid),
    .req_packet_o      (req_packet),
    .req_ready_i       (req_ready),
    .rsp_valid_i       (rsp_valid),
    .rsp_packet_i      (rsp_packet),
    .rsp_ready_o       (rsp_ready)
  );

  // Request buffer, default depth
  link_fifo link_fifo_inst (
    .clk_main_a0_i     (clk_main_a0),
    .rst_main_n_sync_i (rst_main_n_sync),
    .push_valid_i      (req_valid),
    .push_packet_i     (req_packet),
    .push_ready_o      (req_ready),
    .pop_valid_o       (pop_valid),
    .pop_packet_o      (pop_packet),
    .pop_ready_i       (pop_ready)
  );

  tile_endpoint tile_endpoint_inst (
    .clk_main_a0_i     (clk_main_a0),
    .rst_main_n_sync_i (rst_main_n_sync),
    .req_valid_i       (pop_valid),
    .req_packet_i      (pop_packet),
    .req_ready_o       (pop_ready),
    .rsp_valid_o       (rsp_valid),
    .rsp_packet_o      (rsp_packet),
    .rsp_ready_i       (rsp_ready)
  );

endmodule

// ==== design/link_fifo.sv ====
// Circular request buffer between the bridge and the tile endpoint
// DEPTH need not be a power of two; 2, 4 and 8 are the intended sizes
// Output is registered storage, so a push shows up one cycle later

`timescale 1ns/1ps

module link_fifo
  import mc_link_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic         clk_main_a0_i,
  input  logic         rst_main_n_sync_i,
  input  logic         push_valid_i,
  input  link_packet_u push_packet_i,
  output logic         push_ready_o,
  output logic         pop_valid_o,
  output link_packet_u pop_packet_o,
  input  logic         pop_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  link_packet_u     mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_packet_o = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // Pointers and occupancy
  always_ff @(posedge clk_main_a0_i) begin
    if (!rst_main_n_sync_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_packet_i;
    end
  end

endmodule

// ==== design/mc_link_pkg.sv ====
// Widths, codes and the link packet shared by the bridge, buffer and endpoint
// Link packets carry one 32-bit word per request, no bursts

package mc_link_pkg;

  `include "mc_link_defs.svh"

  // --------------------
  // AXI4-Lite host port
  // --------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = 4;
  localparam int AXIL_RESP_W = 2;

  localparam logic [AXIL_RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [AXIL_RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Endpoint memory
  localparam int DMEM_WORDS  = 256;
  localparam int DMEM_ADDR_W = 8;

  // --------------------
  // Link packet
  // --------------------
  localparam logic LINK_OP_STORE = 1'b1;
  localparam logic LINK_OP_LOAD  = 1'b0;

  localparam int LINK_W = 1 + AXIL_STRB_W + DMEM_ADDR_W + AXIL_DATA_W;

  // Bridge FSM encodings
  localparam logic [1:0] BR_IDLE = 2'd0;
  localparam logic [1:0] BR_SEND = 2'd1;
  localparam logic [1:0] BR_WAIT = 2'd2;
  localparam logic [1:0] BR_RESP = 2'd3;

  // One 45-bit link word, read as a request or as a response
  typedef union packed {
    struct packed {
      logic                   op;
      logic [AXIL_STRB_W-1:0] mask;
      logic [DMEM_ADDR_W-1:0] addr;
      logic [AXIL_DATA_W-1:0] data;
    } req;
    struct packed {
      logic                                 op;
      logic [AXIL_STRB_W+DMEM_ADDR_W-1:0]   pad;
      logic [AXIL_DATA_W-1:0]               data;
    } resp;
  } link_packet_u;

endpackage

// ==== design/ocl_host_bridge.sv ====
// AXI4-Lite slave that serves one host transaction at a time
// Reads win over writes when both arrive in the same idle cycle
// A write is taken only with AW and W valid together
// ID region accesses are answered here and never reach the link

`timescale 1ns/1ps

module ocl_host_bridge
  import mc_link_pkg::*;
(
  input  logic                   clk_main_a0_i,
  input  logic                   rst_main_n_sync_i,
  // Host AXI4-Lite
  input  logic                   awvalid_i,
  input  logic [AXIL_ADDR_W-1:0] awaddr_i,
  output logic                   awready_o,
  input  logic                   wvalid_i,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  input  logic [AXIL_STRB_W-1:0] wstrb_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output logic [AXIL_RESP_W-1:0] bresp_o,
  input  logic                   bready_i,
  input  logic                   arvalid_i,
  input  logic [AXIL_ADDR_W-1:0] araddr_i,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output logic [AXIL_RESP_W-1:0] rresp_o,
  input  logic                   rready_i,
  // Request link
  output logic                   req_valid_o,
  output link_packet_u           req_packet_o,
  input  logic                   req_ready_i,
  // Response link
  input  logic                   rsp_valid_i,
  input  link_packet_u           rsp_packet_i,
  output logic                   rsp_ready_o
);

  logic [1:0]             state_q;
  logic                   is_read_q;
  link_packet_u           req_q;
  logic [AXIL_DATA_W-1:0] rdata_q;
  logic [AXIL_RESP_W-1:0] resp_q;

  logic ar_hs;
  logic aw_hs;
  logic rsp_hs;
  logic ar_id;
  logic aw_id;

  assign ar_id = araddr_i[ID_REGION_BIT];
  assign aw_id = awaddr_i[ID_REGION_BIT];

  // Ready only in idle and only toward a valid request
  assign arready_o = (state_q == BR_IDLE) && arvalid_i;
  assign awready_o = (state_q == BR_IDLE) && !arvalid_i && awvalid_i && wvalid_i;
  assign wready_o  = awready_o;

  assign ar_hs  = arready_o;
  assign aw_hs  = awready_o;
  assign rsp_hs = rsp_valid_i && rsp_ready_o;

  assign req_valid_o  = (state_q == BR_SEND);
  assign req_packet_o = req_q;
  // Endpoint stalls while a host response is outstanding
  assign rsp_ready_o  = (state_q == BR_WAIT);

  assign rvalid_o = (state_q == BR_RESP) && is_read_q;
  assign bvalid_o = (state_q == BR_RESP) && !is_read_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;
  assign bresp_o  = resp_q;

  // --------------------
  // Transaction FSM
  // --------------------
  always_ff @(posedge clk_main_a0_i) begin
    if (!rst_main_n_sync_i) begin
      state_q   <= BR_IDLE;
      is_read_q <= 1'b0;
    end else begin
      case (state_q)
        BR_IDLE: begin
          if (ar_hs) begin
            is_read_q <= 1'b1;
            state_q   <= ar_id ? BR_RESP : BR_SEND;
          end else if (aw_hs) begin
            is_read_q <= 1'b0;
            state_q   <= aw_id ? BR_RESP : BR_SEND;
          end
        end
        BR_SEND: begin
          if (req_ready_i) begin
            state_q <= BR_WAIT;
          end
        end
        BR_WAIT: begin
          // Beat kind follows the op echoed in the response
          if (rsp_hs) begin
            is_read_q <= (rsp_packet_i.resp.op == LINK_OP_LOAD);
            state_q   <= BR_RESP;
          end
        end
        default: begin
          if ((rvalid_o && rready_i) || (bvalid_o && bready_i)) begin
            state_q <= BR_IDLE;
          end
        end
      endcase
    end
  end

  // Request packet and host response payload
  always_ff @(posedge clk_main_a0_i) begin
    if (ar_hs) begin
      req_q.req.op   <= LINK_OP_LOAD;
      req_q.req.mask <= '0;
      req_q.req.addr <= araddr_i[DMEM_ADDR_W+1:2];
      req_q.req.data <= '0;
      rdata_q        <= araddr_i[2] ? CL_SH_ID1 : CL_SH_ID0;
      resp_q         <= RESP_OKAY;
    end else if (aw_hs) begin
      req_q.req.op   <= LINK_OP_STORE;
      req_q.req.mask <= wstrb_i;
      req_q.req.addr <= awaddr_i[DMEM_ADDR_W+1:2];
      req_q.req.data <= wdata_i;
      rdata_q        <= '0;
      // ID words are read only
      resp_q         <= aw_id ? RESP_SLVERR : RESP_OKAY;
    end else if (rsp_hs) begin
      rdata_q <= rsp_packet_i.resp.data;
      resp_q  <= RESP_OKAY;
    end
  end

endmodule

// ==== design/tile_endpoint.sv ====
// Single tile endpoint with a DMEM_WORDS x 32-bit data memory
// One request in flight; a new one waits until the response is taken
// Memory contents are undefined until written

`timescale 1ns/1ps

module tile_endpoint
  import mc_link_pkg::*;
(
  input  logic         clk_main_a0_i,
  input  logic         rst_main_n_sync_i,
  input  logic         req_valid_i,
  input  link_packet_u req_packet_i,
  output logic         req_ready_o,
  output logic         rsp_valid_o,
  output link_packet_u rsp_packet_o,
  input  logic         rsp_ready_i
);

  logic [AXIL_DATA_W-1:0] dmem_q [DMEM_WORDS];
  logic                   rsp_valid_q;
  link_packet_u           rsp_q;

  logic req_hs;
  logic is_store;

  assign req_ready_o  = !rsp_valid_q;
  assign req_hs       = req_valid_i && req_ready_o;
  assign is_store     = (req_packet_i.req.op == LINK_OP_STORE);
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_packet_o = rsp_q;

  // --------------------
  // Response handshake
  // --------------------
  always_ff @(posedge clk_main_a0_i) begin
    if (!rst_main_n_sync_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_hs) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response word echoes the op, stores return zero data
  always_ff @(posedge clk_main_a0_i) begin
    if (req_hs) begin
      rsp_q.resp.op  <= req_packet_i.req.op;
      rsp_q.resp.pad <= '0;
      if (is_store) begin
        rsp_q.resp.data <= '0;
      end else begin
        rsp_q.resp.data <= dmem_q[req_packet_i.req.addr];
      end
    end
  end

  // Byte-masked store
  always_ff @(posedge clk_main_a0_i) begin
    if (req_hs && is_store) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (req_packet_i.req.mask[b]) begin
          dmem_q[req_packet_i.req.addr][b*8 +: 8] <= req_packet_i.req.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== include/mc_link_defs.svh ====
// Address map and PCI ID constants for the host control port
// Pulled into mc_link_pkg, so it is not meant to be included on its own
// The ID region sits above the 1 KB memory window of the tile endpoint

`ifndef MC_LINK_DEFS_SVH
`define MC_LINK_DEFS_SVH

// --------------------
// PCI ID words
// --------------------
// Vendor ID in the low half, device ID in the high half
localparam logic [31:0] CL_SH_ID0 = 32'hf000_1d0f;
// Subsystem vendor ID in the low half, subsystem ID in the high half
localparam logic [31:0] CL_SH_ID1 = 32'h1d51_fedc;

// Address bit that selects the ID region instead of memory
localparam int ID_REGION_BIT = 12;

`endif

// ==== sources.f ====
+incdir+include
design/mc_link_pkg.sv
design/ocl_host_bridge.sv
design/link_fifo.sv
design/tile_endpoint.sv
design/cl_manycore_top.sv
verification/tb_clk_gen.sv
verification/cl_manycore_props.sv
verification/cl_manycore_tb.sv

// ==== verification/cl_manycore_props.sv ====
// AXI4-Lite response-channel rules for the host port of cl_manycore_top
// Bound into the top level; all properties are off while reset is low
// fail_count is read hierarchically by the testbench

`timescale 1ns/1ps

module cl_manycore_props
  import mc_link_pkg::*;
(
  input logic                   clk_main_a0_i,
  input logic                   rst_main_n_sync_i,
  input logic                   arready_i,
  input logic                   bvalid_i,
  input logic [AXIL_RESP_W-1:0] bresp_i,
  input logic                   bready_i,
  input logic                   rvalid_i,
  input logic [AXIL_DATA_W-1:0] rdata_i,
  input logic [AXIL_RESP_W-1:0] rresp_i,
  input logic                   rready_i
);

  int unsigned fail_count = 0;

  // --------------------
  // Response hold
  // --------------------
  b_hold: assert property (@(posedge clk_main_a0_i) disable iff (!rst_main_n_sync_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
  else begin
    $error("bvalid dropped or bresp changed before bready");
    fail_count++;
  end

  r_hold: assert property (@(posedge clk_main_a0_i) disable iff (!rst_main_n_sync_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
  else begin
    $error("rvalid dropped or R payload changed before rready");
    fail_count++;
  end

  // One host transaction at a time
  b_excl: assert property (@(posedge clk_main_a0_i) disable iff (!rst_main_n_sync_i)
    $rose(bvalid_i) |-> !rvalid_i)
  else begin
    $error("bvalid rose while rvalid was pending");
    fail_count++;
  end

  r_excl: assert property (@(posedge clk_main_a0_i) disable iff (!rst_main_n_sync_i)
    $rose(rvalid_i) |-> !bvalid_i)
  else begin
    $error("rvalid rose while bvalid was pending");
    fail_count++;
  end

  ar_block: assert property (@(posedge clk_main_a0_i) disable iff (!rst_main_n_sync_i)
    rvalid_i |-> !arready_i)
  else begin
    $error("arready high while rvalid was pending");
    fail_count++;
  end

endmodule

// ==== verification/cl_manycore_tb.sv ====
// Table-driven testbench for cl_manycore_top
// The table runs twice, first with bready/rready always high, then with
// random ready delays; every entry must give the same result in both passes
// Entries depend on earlier ones, so the table order matters

`timescale 1ns/1ps

module cl_manycore_tb
  import mc_link_pkg::*;
();

  localparam int NUM_PASSES = 2;
  localparam int CYCLES_PER_ENTRY = 64;
  localparam logic [AXIL_ADDR_W-1:0] ID_BASE = 32'h1 << ID_REGION_BIT;

  typedef struct {
    string                  name;
    bit                     is_write;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
    logic [AXIL_DATA_W-1:0] exp_data;
    logic [AXIL_RESP_W-1:0] exp_resp;
  } vector_t;

  logic clk;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [AXIL_ADDR_W-1:0] awaddr, araddr;
  logic [AXIL_DATA_W-1:0] wdata, rdata;
  logic [AXIL_STRB_W-1:0] wstrb;
  logic [AXIL_RESP_W-1:0] bresp, rresp;

  vector_t vectors[$];
  integer  seed;
  int      cycle_count = 0;
  int      cycle_limit = 0;
  int      data_errors = 0;
  int      resp_errors = 0;
  int      other_errors = 0;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk));

  cl_manycore_top cl_manycore_top_inst (
    .clk_main_a0 (clk),     .rst_main_n_sync (rst_n),
    .awvalid_i   (awvalid), .awaddr_i (awaddr), .awready_o (awready),
    .wvalid_i    (wvalid),  .wdata_i  (wdata),  .wstrb_i   (wstrb),  .wready_o (wready),
    .bvalid_o    (bvalid),  .bresp_o  (bresp),  .bready_i  (bready),
    .arvalid_i   (arvalid), .araddr_i (araddr), .arready_o (arready),
    .rvalid_o    (rvalid),  .rdata_o  (rdata),  .rresp_o   (rresp),  .rready_i (rready)
  );

  bind cl_manycore_top cl_manycore_props cl_manycore_props_inst (
    .clk_main_a0_i (clk_main_a0), .rst_main_n_sync_i (rst_main_n_sync),
    .arready_i (arready_o), .bvalid_i (bvalid_o), .bresp_i (bresp_o), .bready_i (bready_i),
    .rvalid_i (rvalid_o), .rdata_i (rdata_o), .rresp_i (rresp_o), .rready_i (rready_i)
  );

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string name, input logic [AXIL_DATA_W-1:0] exp,
                            input logic [AXIL_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: data expected 0x%08h, actual 0x%08h", name, exp, act);
      data_errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic [AXIL_RESP_W-1:0] exp,
                            input logic [AXIL_RESP_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: resp expected %02b, actual %02b", name, exp, act);
      resp_errors++;
    end
  endtask

  task automatic add_vector(input string name, input bit is_write,
                            input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data,
                            input logic [AXIL_STRB_W-1:0] strb,
                            input logic [AXIL_DATA_W-1:0] exp_data,
                            input logic [AXIL_RESP_W-1:0] exp_resp);
    vector_t v;
    v.name = name;
    v.is_write = is_write;
    v.addr = addr;
    v.data = data;
    v.strb = strb;
    v.exp_data = exp_data;
    v.exp_resp = exp_resp;
    vectors.push_back(v);
  endtask

  // Partial writes merge deadbeef into 12345678 on bytes 0 and 2
  // and 00112233 into a5a55a5a on bytes 1 and 3
  // Address bit 10 lies outside the word index
  // The ID write shares word index 0 and must leave word 0 alone
  task automatic build_table();
    add_vector("wr_word0", 1, 32'h000, 32'h1234_5678, 4'hf, '0, RESP_OKAY);
    add_vector("wr_word1", 1, 32'h004, 32'ha5a5_5a5a, 4'hf, '0, RESP_OKAY);
    add_vector("rd_word0", 0, 32'h000, '0, '0, 32'h1234_5678, RESP_OKAY);
    add_vector("rd_word1", 0, 32'h004, '0, '0, 32'ha5a5_5a5a, RESP_OKAY);
    add_vector("wr_part0", 1, 32'h000, 32'hdead_beef, 4'b0101, '0, RESP_OKAY);
    add_vector("rd_part0", 0, 32'h000, '0, '0, 32'h12ad_56ef, RESP_OKAY);
    add_vector("wr_part1", 1, 32'h004, 32'h0011_2233, 4'b1010, '0, RESP_OKAY);
    add_vector("rd_part1", 0, 32'h004, '0, '0, 32'h00a5_225a, RESP_OKAY);
    add_vector("rd_alias", 0, 32'h400, '0, '0, 32'h12ad_56ef, RESP_OKAY);
    add_vector("rd_id0", 0, ID_BASE, '0, '0, CL_SH_ID0, RESP_OKAY);
    add_vector("rd_id1", 0, ID_BASE | 32'h4, '0, '0, CL_SH_ID1, RESP_OKAY);
    add_vector("wr_id0", 1, ID_BASE, 32'h0bad_0bad, 4'hf, '0, RESP_SLVERR);
    add_vector("rd_word0_kept", 0, 32'h000, '0, '0, 32'h12ad_56ef, RESP_OKAY);
    add_vector("rd_id0_again", 0, ID_BASE, '0, '0, CL_SH_ID0, RESP_OKAY);
  endtask

  // --------------------
  // Host driver
  // --------------------
  // Called and returns on a falling edge
  task automatic host_write(input vector_t v, input int delay,
                            output logic [AXIL_RESP_W-1:0] resp);
    awvalid = 1'b1;
    awaddr  = v.addr;
    wvalid  = 1'b1;
    wdata   = v.data;
    wstrb   = v.strb;
    @(posedge clk);
    while (!(awready && wready)) @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (delay) @(negedge clk);
    bready = 1'b1;
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic host_read(input vector_t v, input int delay,
                           output logic [AXIL_DATA_W-1:0] data,
                           output logic [AXIL_RESP_W-1:0] resp);
    arvalid = 1'b1;
    araddr  = v.addr;
    @(posedge clk);
    while (!arready) @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    repeat (delay) @(negedge clk);
    rready = 1'b1;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the DUT did not finish the table within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [AXIL_DATA_W-1:0] act_data;
    logic [AXIL_RESP_W-1:0] act_resp;
    string                  tag;
    int                     delay;
    int                     total;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    seed    = 32'hdd3f_e1b1;
    build_table();
    cycle_limit = CYCLES_PER_ENTRY * vectors.size() * NUM_PASSES + 16;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (bvalid !== 1'b0 || rvalid !== 1'b0 || awready !== 1'b0 ||
        wready !== 1'b0 || arready !== 1'b0) begin
      $display("After reset a valid or ready output of the host port is not low");
      other_errors++;
    end
    for (int pass = 0; pass < NUM_PASSES; pass++) begin
      foreach (vectors[i]) begin
        tag   = $sformatf("%s/pass%0d", vectors[i].name, pass);
        // Up to 7 cycles, long enough to stall memory responses too
        delay = (pass == 0) ? 0 : int'($unsigned($random(seed)) % 8);
        if (vectors[i].is_write) begin
          host_write(vectors[i], delay, act_resp);
          check_resp(tag, vectors[i].exp_resp, act_resp);
        end else begin
          host_read(vectors[i], delay, act_data, act_resp);
          check_resp(tag, vectors[i].exp_resp, act_resp);
          check_data(tag, vectors[i].exp_data, act_data);
        end
      end
    end
    other_errors += cl_manycore_top_inst.cl_manycore_props_inst.fail_count;
    total = data_errors + resp_errors + other_errors;
    $display("Errors: data %0d, resp %0d, other %0d", data_errors, resp_errors, other_errors);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
// Free-running testbench clock, starts low at time 0
// HALF_PERIOD is in ns, the default gives a 10 ns period

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule
